// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/100ps -j 0
TOP      = tb_ooo_core
FILELIST = tb.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard test/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== hdl/core_pkg.sv ====
package core_pkg;

    // Data and PC width
    localparam int XLEN = 32;

    // Destination register index
    localparam int RD_W = 5;

    // Instruction word fields
    localparam int OPC_HI = 31;
    localparam int OPC_LO = 28;
    localparam int RD_HI  = 27;
    localparam int RD_LO  = 23;

    // Shift amount for OP_SLL sits in the low bits
    localparam int SHAMT_W  = 5;
    localparam int SHAMT_HI = 4;
    localparam int SHAMT_LO = 0;

    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_AND = 4'd2,
        OP_XOR = 4'd3,
        OP_SLL = 4'd4,
        OP_MUL = 4'd8    // Only multiplier opcode
    } opcode_t;

    typedef enum logic [1:0] {
        EXC_NONE     = 2'd0,
        EXC_ILLEGAL  = 2'd1,
        EXC_OVERFLOW = 2'd2
    } exc_t;

endpackage

// ==== hdl/exec_units.sv ====
`timescale 1ns/100ps

module exec_units #(
    parameter int MUL_LATENCY = 3,
    parameter int ROB_SIZE    = 8
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     flush,
    input  logic                                     issue_alu,
    input  logic                                     issue_mul,
    input  core_pkg::opcode_t                        issue_op,
    input  logic [core_pkg::XLEN-1:0]                issue_a,
    input  logic [core_pkg::XLEN-1:0]                issue_b,
    input  logic [core_pkg::SHAMT_W-1:0]             issue_shamt,
    input  logic [((ROB_SIZE > 1) ? $clog2(ROB_SIZE) : 1)-1:0] issue_idx,
    output logic                                     alu_done,
    output logic [((ROB_SIZE > 1) ? $clog2(ROB_SIZE) : 1)-1:0] alu_idx,
    output logic [core_pkg::XLEN-1:0]                alu_value,
    output core_pkg::exc_t                           alu_exc,
    output logic                                     mul_done,
    output logic [((ROB_SIZE > 1) ? $clog2(ROB_SIZE) : 1)-1:0] mul_idx,
    output logic [core_pkg::XLEN-1:0]                mul_value
);

    import core_pkg::*;

    localparam int IDX_W = (ROB_SIZE > 1) ? $clog2(ROB_SIZE) : 1;

    logic [XLEN-1:0] alu_result;
    exc_t            alu_fault;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;

    assign sum  = issue_a + issue_b;
    assign diff = issue_a - issue_b;

    always_comb begin
        alu_result = '0;
        alu_fault  = EXC_NONE;
        case (issue_op)
            OP_ADD: begin
                alu_result = sum;
                // Same operand signs, result sign flipped
                if (issue_a[XLEN-1] == issue_b[XLEN-1] && sum[XLEN-1] != issue_a[XLEN-1])
                    alu_fault = EXC_OVERFLOW;
            end
            OP_SUB: begin
                alu_result = diff;
                if (issue_a[XLEN-1] != issue_b[XLEN-1] && diff[XLEN-1] != issue_a[XLEN-1])
                    alu_fault = EXC_OVERFLOW;
            end
            OP_AND:  alu_result = issue_a & issue_b;
            OP_XOR:  alu_result = issue_a ^ issue_b;
            OP_SLL:  alu_result = issue_a << issue_shamt;
            default: alu_fault = EXC_ILLEGAL;    // MUL never gets here
        endcase
    end

    // Single-cycle ALU, an issue during flush belongs to a dead entry
    always_ff @(posedge clk) begin
        if (reset)
            alu_done <= 1'b0;
        else
            alu_done <= issue_alu && !flush;
    end

    always_ff @(posedge clk) begin
        if (issue_alu) begin
            alu_idx   <= issue_idx;
            alu_value <= alu_result;
            alu_exc   <= alu_fault;
        end
    end

    // Multiplier shift pipeline, one new op per cycle
    logic [MUL_LATENCY-1:0] mul_v;
    logic [IDX_W-1:0]       mul_i [MUL_LATENCY];
    logic [XLEN-1:0]        mul_p [MUL_LATENCY];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            mul_v <= '0;
        end else begin
            mul_v[0] <= issue_mul;
            for (int i = 1; i < MUL_LATENCY; i++)
                mul_v[i] <= mul_v[i-1];
        end
    end

    always_ff @(posedge clk) begin
        mul_i[0] <= issue_idx;
        mul_p[0] <= issue_a * issue_b;    // Low XLEN bits kept
        for (int i = 1; i < MUL_LATENCY; i++) begin
            mul_i[i] <= mul_i[i-1];
            mul_p[i] <= mul_p[i-1];
        end
    end

    assign mul_done  = mul_v[MUL_LATENCY-1];
    assign mul_idx   = mul_i[MUL_LATENCY-1];
    assign mul_value = mul_p[MUL_LATENCY-1];

endmodule

// ==== hdl/instr_decode.sv ====
`timescale 1ns/100ps

module instr_decode #(
    parameter int ROB_SIZE = 8
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     instr_valid,
    input  logic [core_pkg::XLEN-1:0]                instr,
    input  logic [core_pkg::XLEN-1:0]                operand_a,
    input  logic [core_pkg::XLEN-1:0]                operand_b,
    input  logic                                     full,
    input  logic [((ROB_SIZE > 1) ? $clog2(ROB_SIZE) : 1)-1:0] alloc_idx,
    input  logic                                     flush,
    output logic                                     alloc,
    output logic [core_pkg::RD_W-1:0]                alloc_rd,
    output logic                                     issue_alu,
    output logic                                     issue_mul,
    output core_pkg::opcode_t                        issue_op,
    output logic [core_pkg::XLEN-1:0]                issue_a,
    output logic [core_pkg::XLEN-1:0]                issue_b,
    output logic [core_pkg::SHAMT_W-1:0]             issue_shamt,
    output logic [((ROB_SIZE > 1) ? $clog2(ROB_SIZE) : 1)-1:0] issue_idx
);

    import core_pkg::*;

    localparam int IDX_W = (ROB_SIZE > 1) ? $clog2(ROB_SIZE) : 1;

    opcode_t opc;
    logic    to_mul;

    assign opc      = opcode_t'(instr[OPC_HI:OPC_LO]);
    assign alloc_rd = instr[RD_HI:RD_LO];
    assign alloc    = instr_valid && !full;    // Strobes while full are dropped

    // Pick the execution unit
    always_comb begin
        case (opc)
            OP_MUL:                               to_mul = 1'b1;
            OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_SLL: to_mul = 1'b0;
            default:                              to_mul = 1'b0; // Illegal, ALU flags it
        endcase
    end

    // Issue strobes last a single cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            issue_alu <= 1'b0;
            issue_mul <= 1'b0;
        end else begin
            issue_alu <= alloc && !to_mul;
            issue_mul <= alloc && to_mul;
        end
    end

    // Issue payload, tagged with the entry the buffer hands out
    always_ff @(posedge clk) begin
        if (alloc) begin
            issue_op    <= opc;
            issue_a     <= operand_a;
            issue_b     <= operand_b;
            issue_shamt <= instr[SHAMT_HI:SHAMT_LO];
            issue_idx   <= alloc_idx;
        end else if (flush) begin
            issue_op    <= OP_ADD;
            issue_a     <= '0;
            issue_b     <= '0;
            issue_shamt <= '0;
            issue_idx   <= IDX_W'(0);
        end
    end

endmodule

// ==== hdl/ooo_core.sv ====
`timescale 1ns/100ps

module ooo_core #(
    parameter int ROB_SIZE    = 8,
    parameter int MUL_LATENCY = 3
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        instr_valid,
    input  logic [core_pkg::XLEN-1:0]   instr,
    input  logic [core_pkg::XLEN-1:0]   instr_pc,
    input  logic [core_pkg::XLEN-1:0]   operand_a,
    input  logic [core_pkg::XLEN-1:0]   operand_b,
    output logic                        full,
    output logic                        commit_valid,
    output logic [core_pkg::XLEN-1:0]   commit_pc,
    output logic [core_pkg::RD_W-1:0]   commit_rd,
    output logic [core_pkg::XLEN-1:0]   commit_value,
    output logic                        exc_valid,
    output logic [core_pkg::XLEN-1:0]   exc_pc,
    output core_pkg::exc_t              exc_cause
);

    import core_pkg::*;

    localparam int IDX_W = (ROB_SIZE > 1) ? $clog2(ROB_SIZE) : 1;

    // Decode to buffer
    logic             alloc;
    logic [RD_W-1:0]  alloc_rd;
    logic [IDX_W-1:0] alloc_idx;
    logic             flush;

    // Decode to execute
    logic                issue_alu;
    logic                issue_mul;
    opcode_t             issue_op;
    logic [XLEN-1:0]     issue_a;
    logic [XLEN-1:0]     issue_b;
    logic [SHAMT_W-1:0]  issue_shamt;
    logic [IDX_W-1:0]    issue_idx;

    // Completion ports
    logic             alu_done;
    logic [IDX_W-1:0] alu_idx;
    logic [XLEN-1:0]  alu_value;
    exc_t             alu_exc;
    logic             mul_done;
    logic [IDX_W-1:0] mul_idx;
    logic [XLEN-1:0]  mul_value;

    instr_decode #(
        .ROB_SIZE    (ROB_SIZE)
    ) instr_decode_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .full        (full),
        .alloc_idx   (alloc_idx),
        .flush       (flush),
        .alloc       (alloc),
        .alloc_rd    (alloc_rd),
        .issue_alu   (issue_alu),
        .issue_mul   (issue_mul),
        .issue_op    (issue_op),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .issue_shamt (issue_shamt),
        .issue_idx   (issue_idx)
    );

    exec_units #(
        .MUL_LATENCY (MUL_LATENCY),
        .ROB_SIZE    (ROB_SIZE)
    ) exec_units_i (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .issue_alu   (issue_alu),
        .issue_mul   (issue_mul),
        .issue_op    (issue_op),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .issue_shamt (issue_shamt),
        .issue_idx   (issue_idx),
        .alu_done    (alu_done),
        .alu_idx     (alu_idx),
        .alu_value   (alu_value),
        .alu_exc     (alu_exc),
        .mul_done    (mul_done),
        .mul_idx     (mul_idx),
        .mul_value   (mul_value)
    );

    reorder_buffer #(
        .ROB_SIZE     (ROB_SIZE)
    ) reorder_buffer_i (
        .clk          (clk),
        .reset        (reset),
        .alloc        (alloc),
        .alloc_pc     (instr_pc),
        .alloc_rd     (alloc_rd),
        .alu_done     (alu_done),
        .alu_idx      (alu_idx),
        .alu_value    (alu_value),
        .alu_exc      (alu_exc),
        .mul_done     (mul_done),
        .mul_idx      (mul_idx),
        .mul_value    (mul_value),
        .full         (full),
        .alloc_idx    (alloc_idx),
        .flush        (flush),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_value (commit_value),
        .exc_valid    (exc_valid),
        .exc_pc       (exc_pc),
        .exc_cause    (exc_cause)
    );

endmodule

// ==== hdl/reorder_buffer.sv ====
`timescale 1ns/100ps

module reorder_buffer #(
    parameter int ROB_SIZE = 8
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     alloc,
    input  logic [core_pkg::XLEN-1:0]                alloc_pc,
    input  logic [core_pkg::RD_W-1:0]                alloc_rd,
    input  logic                                     alu_done,
    input  logic [((ROB_SIZE > 1) ? $clog2(ROB_SIZE) : 1)-1:0] alu_idx,
    input  logic [core_pkg::XLEN-1:0]                alu_value,
    input  core_pkg::exc_t                           alu_exc,
    input  logic                                     mul_done,
    input  logic [((ROB_SIZE > 1) ? $clog2(ROB_SIZE) : 1)-1:0] mul_idx,
    input  logic [core_pkg::XLEN-1:0]                mul_value,
    output logic                                     full,
    output logic [((ROB_SIZE > 1) ? $clog2(ROB_SIZE) : 1)-1:0] alloc_idx,
    output logic                                     flush,
    output logic                                     commit_valid,
    output logic [core_pkg::XLEN-1:0]                commit_pc,
    output logic [core_pkg::RD_W-1:0]                commit_rd,
    output logic [core_pkg::XLEN-1:0]                commit_value,
    output logic                                     exc_valid,
    output logic [core_pkg::XLEN-1:0]                exc_pc,
    output core_pkg::exc_t                           exc_cause
);

    import core_pkg::*;

    localparam int IDX_W = (ROB_SIZE > 1) ? $clog2(ROB_SIZE) : 1;
    localparam int CNT_W = $clog2(ROB_SIZE + 1);

    // Entry storage
    logic [XLEN-1:0]     ent_pc    [ROB_SIZE];
    logic [RD_W-1:0]     ent_rd    [ROB_SIZE];
    logic [XLEN-1:0]     ent_value [ROB_SIZE];
    exc_t                ent_exc   [ROB_SIZE];
    logic [ROB_SIZE-1:0] ent_valid;
    logic [ROB_SIZE-1:0] ent_complete;

    logic [IDX_W-1:0] head;
    logic [IDX_W-1:0] tail;
    logic [CNT_W-1:0] count;

    logic do_alloc;
    logic head_ready;
    logic head_fault;
    logic retire;

    assign full      = (count == CNT_W'(ROB_SIZE));
    assign alloc_idx = tail;
    assign do_alloc  = alloc && !full;

    assign head_ready = ent_valid[head] && ent_complete[head];
    assign head_fault = head_ready && (ent_exc[head] != EXC_NONE);
    assign retire     = head_ready && !head_fault;

    function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
        next_idx = (idx == IDX_W'(ROB_SIZE - 1)) ? IDX_W'(0) : idx + IDX_W'(1);
    endfunction

    // Control state, pointers and retirement strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            ent_valid    <= '0;
            ent_complete <= '0;
            commit_valid <= 1'b0;
            exc_valid    <= 1'b0;
            flush        <= 1'b0;
        end else begin
            commit_valid <= 1'b0;
            exc_valid    <= 1'b0;
            flush        <= 1'b0;
            if (head_fault) begin
                // Faulting head drops itself and everything younger
                exc_valid    <= 1'b1;
                flush        <= 1'b1;
                head         <= '0;
                tail         <= '0;
                count        <= '0;
                ent_valid    <= '0;
                ent_complete <= '0;
            end else begin
                if (do_alloc) begin
                    ent_valid[tail]    <= 1'b1;
                    ent_complete[tail] <= 1'b0;
                    tail               <= next_idx(tail);
                end
                // Completions seen during flush are from discarded entries
                if (alu_done && !flush)
                    ent_complete[alu_idx] <= 1'b1;
                if (mul_done && !flush)
                    ent_complete[mul_idx] <= 1'b1;
                if (retire) begin
                    commit_valid    <= 1'b1;
                    ent_valid[head] <= 1'b0;
                    head            <= next_idx(head);
                end
                count <= count + CNT_W'(do_alloc) - CNT_W'(retire);
            end
        end
    end

    // Entry payload and retirement data
    always_ff @(posedge clk) begin
        if (do_alloc) begin
            ent_pc[tail] <= alloc_pc;
            ent_rd[tail] <= alloc_rd;
        end
        if (alu_done) begin
            ent_value[alu_idx] <= alu_value;
            ent_exc[alu_idx]   <= alu_exc;
        end
        if (mul_done) begin
            ent_value[mul_idx] <= mul_value;
            ent_exc[mul_idx]   <= EXC_NONE;    // Multiplies never fault
        end
        if (retire) begin
            commit_pc    <= ent_pc[head];
            commit_rd    <= ent_rd[head];
            commit_value <= ent_value[head];
        end
        if (head_fault) begin
            exc_pc    <= ent_pc[head];
            exc_cause <= ent_exc[head];
        end
    end

endmodule

// ==== tb.f ====
+incdir+test
hdl/core_pkg.sv
hdl/instr_decode.sv
hdl/exec_units.sv
hdl/reorder_buffer.sv
hdl/ooo_core.sv
test/tb_ooo_core.sv

// ==== test/tb_tasks.svh ====
// Expected retirement of one accepted instruction
typedef struct packed {
    logic            is_exc;
    logic [XLEN-1:0] pc;
    logic [RD_W-1:0] rd;
    logic [XLEN-1:0] value;
    exc_t            cause;
} retire_t;

retire_t         expect_q[$];
logic [XLEN-1:0] next_pc = 32'h0000_1000;

task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "Run stopped at the first failure");
endtask

task automatic compare_value(input string field, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
    if (act !== exp)
        abort_run($sformatf("Error: %s %s expected %h actual %h",
                            current_test, field, exp, act));
endtask

task automatic compare_rd(input string field, input logic [RD_W-1:0] exp,
                          input logic [RD_W-1:0] act);
    if (act !== exp)
        abort_run($sformatf("Error: %s %s expected %0d actual %0d",
                            current_test, field, exp, act));
endtask

task automatic compare_exc(input string field, input exc_t exp, input exc_t act);
    if (act !== exp)
        abort_run($sformatf("Error: %s %s expected %s actual %s",
                            current_test, field, exp.name(), act.name()));
endtask

task automatic compare_flag(input string field, input logic exp, input logic act);
    if (act !== exp)
        abort_run($sformatf("Error: %s %s expected %b actual %b",
                            current_test, field, exp, act));
endtask

// Reference result and cause of one instruction
function automatic void predict(input logic [3:0] opc, input logic [XLEN-1:0] a,
                                input logic [XLEN-1:0] b, input logic [SHAMT_W-1:0] shamt,
                                output logic [XLEN-1:0] value, output exc_t cause);
    logic [XLEN:0] wide;    // Sign-extended by one bit
    value = '0;
    cause = EXC_NONE;
    case (opc)
        OP_ADD, OP_SUB: begin
            if (opc == OP_ADD)
                wide = {a[XLEN-1], a} + {b[XLEN-1], b};
            else
                wide = {a[XLEN-1], a} - {b[XLEN-1], b};
            value = wide[XLEN-1:0];
            if (wide[XLEN] != wide[XLEN-1])
                cause = EXC_OVERFLOW;    // Result does not fit in XLEN signed
        end
        OP_AND:  value = a & b;
        OP_XOR:  value = a ^ b;
        OP_SLL:  value = a << shamt;
        OP_MUL:  value = a * b;
        default: cause = EXC_ILLEGAL;
    endcase
endfunction

// Drive one instruction and record what it should retire as
task automatic send_instr(input logic [3:0] opc, input logic [RD_W-1:0] rd,
                          input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                          input logic [SHAMT_W-1:0] shamt);
    retire_t         exp;
    logic [XLEN-1:0] value;
    exc_t            cause;
    logic            shadowed;
    while (full)
        @(negedge clk);
    // Younger than a fault still waiting to retire, so it gets flushed
    shadowed = (expect_q.size() != 0) && expect_q[$].is_exc;
    predict(opc, a, b, shamt, value, cause);
    if (!shadowed) begin
        exp.is_exc = (cause != EXC_NONE);
        exp.pc     = next_pc;
        exp.rd     = rd;
        exp.value  = value;
        exp.cause  = cause;
        expect_q.push_back(exp);
    end
    instr_valid = 1'b1;
    instr       = {opc, rd, 18'd0, shamt};
    instr_pc    = next_pc;
    operand_a   = a;
    operand_b   = b;
    next_pc     = next_pc + 32'd4;
    @(negedge clk);
    instr_valid = 1'b0;
endtask

task automatic wait_drain();
    while (expect_q.size() != 0)
        @(negedge clk);
    repeat (3) @(negedge clk);    // A late retirement here has nothing to match
endtask

task automatic check_retirement();
    retire_t exp;
    if (expect_q.size() == 0) begin
        abort_run($sformatf("In %s the core retired an instruction nobody expected",
                            current_test));
    end else begin
        exp = expect_q.pop_front();
        if (exp.is_exc) begin
            compare_flag("exc_valid", 1'b1, exc_valid);
            compare_flag("commit_valid", 1'b0, commit_valid);
            compare_value("exc_pc", exp.pc, exc_pc);
            compare_exc("exc_cause", exp.cause, exc_cause);
        end else begin
            compare_flag("commit_valid", 1'b1, commit_valid);
            compare_flag("exc_valid", 1'b0, exc_valid);
            compare_value("commit_pc", exp.pc, commit_pc);
            compare_rd("commit_rd", exp.rd, commit_rd);
            compare_value("commit_value", exp.value, commit_value);
        end
    end
endtask

task automatic single_alu_latency();
    current_test = "single_alu_latency";
    send_instr(OP_ADD, 5'd3, random_bits(16), random_bits(16), 5'd0);
    // Commit lands on the third edge after acceptance
    @(negedge clk);
    compare_flag("commit_valid", 1'b0, commit_valid);
    @(negedge clk);
    compare_flag("commit_valid", 1'b0, commit_valid);
    @(negedge clk);
    compare_flag("commit_valid", 1'b1, commit_valid);
    wait_drain();
endtask

task automatic all_alu_ops();
    opcode_t         ops [5] = '{OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_SLL};
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    current_test = "all_alu_ops";
    for (int round = 0; round < 2; round++) begin
        foreach (ops[i]) begin
            if (ops[i] == OP_ADD || ops[i] == OP_SUB) begin
                a = random_bits(30);    // Stays clear of overflow
                b = random_bits(30);
            end else begin
                a = random_bits(32);
                b = random_bits(32);
            end
            send_instr(ops[i], RD_W'(random_bits(RD_W)), a, b,
                       SHAMT_W'(random_bits(SHAMT_W)));
        end
    end
    wait_drain();
endtask

task automatic out_of_order_completion();
    current_test = "out_of_order_completion";
    send_instr(OP_MUL, 5'd7, random_bits(32), random_bits(32), 5'd0);
    send_instr(OP_AND, 5'd8, random_bits(32), random_bits(32), 5'd0);
    send_instr(OP_XOR, 5'd9, random_bits(32), random_bits(32), 5'd0);
    send_instr(OP_SLL, 5'd10, random_bits(32), 32'd0, SHAMT_W'(random_bits(SHAMT_W)));
    send_instr(OP_ADD, 5'd11, random_bits(20), random_bits(20), 5'd0);
    wait_drain();
endtask

task automatic back_pressure();
    current_test = "back_pressure";
    for (int i = 0; i < ROB_SIZE; i++)
        send_instr(OP_MUL, RD_W'(i + 1), random_bits(32), random_bits(32), 5'd0);
    compare_flag("full", 1'b1, full);
    wait_drain();
endtask

task automatic illegal_opcode();
    current_test = "illegal_opcode";
    send_instr(4'hf, 5'd1, random_bits(32), random_bits(32), 5'd0);
    send_instr(OP_MUL, 5'd2, random_bits(32), random_bits(32), 5'd0);
    send_instr(OP_ADD, 5'd3, random_bits(16), random_bits(16), 5'd0);
    wait_drain();
    send_instr(OP_XOR, 5'd4, random_bits(32), random_bits(32), 5'd0);
    send_instr(OP_SUB, 5'd5, random_bits(24), random_bits(24), 5'd0);
    wait_drain();
endtask

task automatic add_overflow();
    current_test = "add_overflow";
    // Two large positives wrap negative
    send_instr(OP_ADD, 5'd12, {2'b01, 30'(random_bits(30))},
               {2'b01, 30'(random_bits(30))}, 5'd0);
    send_instr(OP_SLL, 5'd13, random_bits(32), 32'd0, 5'd9);
    send_instr(OP_AND, 5'd14, random_bits(32), random_bits(32), 5'd0);
    wait_drain();
    send_instr(OP_MUL, 5'd15, random_bits(32), random_bits(32), 5'd0);
    send_instr(OP_ADD, 5'd16, random_bits(24), random_bits(24), 5'd0);
    wait_drain();
endtask

// ==== test/tb_ooo_core.sv ====
`timescale 1ns/100ps

module tb_ooo_core;

    import core_pkg::*;

    // Small buffer so back-to-back multiplies can fill it
    localparam int ROB_SIZE     = 4;
    localparam int MUL_LATENCY  = 3;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_INSTR    = 30;    // Sum over all directed tests
    localparam int CYCLE_LIMIT  = 2 * NUM_INSTR * (MUL_LATENCY + 4) + RESET_CYCLES;

    logic            clk;
    logic            reset;
    logic            instr_valid;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] instr_pc;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic            full;
    logic            commit_valid;
    logic [XLEN-1:0] commit_pc;
    logic [RD_W-1:0] commit_rd;
    logic [XLEN-1:0] commit_value;
    logic            exc_valid;
    logic [XLEN-1:0] exc_pc;
    exc_t            exc_cause;

    string       current_test = "reset";
    logic [31:0] lfsr_state   = 32'h15df;
    int          cycle_count  = 0;

    ooo_core #(
        .ROB_SIZE     (ROB_SIZE),
        .MUL_LATENCY  (MUL_LATENCY)
    ) ooo_core_i (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_pc     (instr_pc),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .full         (full),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_value (commit_value),
        .exc_valid    (exc_valid),
        .exc_pc       (exc_pc),
        .exc_cause    (exc_cause)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit, low n bits filled
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r          = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    `include "tb_tasks.svh"

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
            abort_run($sformatf("Timeout: the run went past its limit of %0d cycles",
                                CYCLE_LIMIT));
    end

    // Retirement monitor, outputs are settled mid-cycle
    always @(negedge clk) begin
        if (!reset && (commit_valid || exc_valid))
            check_retirement();
    end

    initial begin
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        instr_pc    = '0;
        operand_a   = '0;
        operand_b   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Idle core out of reset
        compare_flag("full", 1'b0, full);
        compare_flag("commit_valid", 1'b0, commit_valid);
        compare_flag("exc_valid", 1'b0, exc_valid);

        single_alu_latency();
        all_alu_ops();
        out_of_order_completion();
        back_pressure();
        illegal_opcode();
        add_overflow();

        repeat (4) @(negedge clk);
        if (expect_q.size() == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            abort_run($sformatf("%0d expected retirements never appeared", expect_q.size()));
        end
    end

endmodule
